// ==== Bender.yml ====
package:
  name: core_frontend

sources:
  - hdl/isa_pkg.sv
  - hdl/frontend_pkg.sv
  - hdl/fetch_if.sv
  - hdl/instr_info_if.sv
  - hdl/fetch_unit.sv
  - hdl/decoder.sv
  - hdl/issue_buffer.sv
  - hdl/core_frontend.sv
  - target: test
    files:
      - test/tb_core_frontend.sv

// ==== hdl/core_frontend.sv ====
// Instruction front end top level
`timescale 1ns/100ps

module core_frontend
  import isa_pkg::*, frontend_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        stop,
  output logic        wb_cyc,
  output logic        wb_stb,
  output addr_t       wb_adr,
  input  word_t       wb_rdata,
  input  logic        wb_ack,
  output logic        issue_valid,
  input  logic        issue_ready,
  output addr_t       issue_pc,
  output instr_name_t issue_name,
  output word_t       issue_imm,
  output reg_idx_t    issue_rd,
  output reg_idx_t    issue_rs1,
  output reg_idx_t    issue_rs2,
  output logic        issue_writes,
  output logic        issue_jumps,
  output logic        issue_uses_imm,
  output station_t    issue_station
);
  fetch_if      fetch_bus ();
  instr_info_if info_bus ();

  fetch_unit fetch_unit_i (
    .clk      (clk),
    .rst      (rst),
    .stop     (stop),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .fetch    (fetch_bus.source)
  );

  decoder decoder_i (
    .fetch      (fetch_bus.decode),
    .instr_info (info_bus.producer)
  );

  issue_buffer issue_buffer_i (
    .clk            (clk),
    .rst            (rst),
    .fetch          (fetch_bus.sink),
    .instr_info     (info_bus.consumer),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_pc       (issue_pc),
    .issue_name     (issue_name),
    .issue_imm      (issue_imm),
    .issue_rd       (issue_rd),
    .issue_rs1      (issue_rs1),
    .issue_rs2      (issue_rs2),
    .issue_writes   (issue_writes),
    .issue_jumps    (issue_jumps),
    .issue_uses_imm (issue_uses_imm),
    .issue_station  (issue_station)
  );

endmodule

// ==== hdl/decoder.sv ====
// RV32I instruction decoder
`timescale 1ns/100ps

module decoder
  import isa_pkg::*, frontend_pkg::*;
(
  fetch_if.decode        fetch,
  instr_info_if.producer instr_info
);
  word_t       instr;
  logic [6:0]  opc;
  logic [2:0]  funct3;
  logic        funct7_b5;
  instr_name_t name;
  word_t       imm;
  reg_idx_t    rd;
  reg_idx_t    rs_1;
  reg_idx_t    rs_2;
  logic        writes;
  logic        jumps;
  logic        uses_imm;
  station_t    st_type;

  assign instr     = fetch.instr;
  assign opc       = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  always_comb begin
    name     = UNKNOWN;
    imm      = '0;
    rd       = '0;
    rs_1     = '0;
    rs_2     = '0;
    writes   = 1'b0;
    jumps    = 1'b0;
    uses_imm = 1'b0;
    st_type  = LS;
    if (instr != '0) begin
      case (opc[4:2])
        3'b000: begin  // Load, store, branch
          rs_1 = instr[19:15];
          case (opc[6:5])
            OPC_LOAD[6:5]: begin
              imm    = {{20{instr[31]}}, instr[31:20]};
              rd     = instr[11:7];
              writes = 1'b1;
              case (funct3)
                3'b000:  name = LB;
                3'b001:  name = LH;
                3'b010:  name = LW;
                3'b100:  name = LBU;
                3'b101:  name = LHU;
                default: name = UNKNOWN;
              endcase
            end
            OPC_STORE[6:5]: begin
              imm  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
              rs_2 = instr[24:20];
              case (funct3)
                3'b000:  name = SB;
                3'b001:  name = SH;
                3'b010:  name = SW;
                default: name = UNKNOWN;
              endcase
            end
            OPC_BRANCH[6:5]: begin
              imm     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
              rs_2    = instr[24:20];
              jumps   = 1'b1;
              st_type = BRANCH;
              case (funct3)
                3'b000:  name = BEQ;
                3'b001:  name = BNE;
                3'b100:  name = BLT;
                3'b101:  name = BGE;
                3'b110:  name = BLTU;
                3'b111:  name = BGEU;
                default: name = UNKNOWN;
              endcase
            end
            default: name = UNKNOWN;
          endcase
        end
        3'b001: begin
          if (opc[6:5] == OPC_JALR[6:5]) begin
            imm     = {{20{instr[31]}}, instr[31:20]};
            rd      = instr[11:7];
            rs_1    = instr[19:15];
            writes  = 1'b1;
            jumps   = 1'b1;
            st_type = BRANCH;
            name    = JALR;
          end
        end
        3'b011: begin
          if (opc[6:5] == OPC_MISC_MEM[6:5]) begin
            st_type = ALU;
            name    = ADDI;  // Fence runs as a no-op
          end else if (opc[6:5] == OPC_JAL[6:5]) begin
            imm     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            rd      = instr[11:7];
            writes  = 1'b1;
            jumps   = 1'b1;
            st_type = BRANCH;
            name    = JAL;
          end
        end
        3'b100: begin  // Op-imm, op, system
          st_type = ALU;
          case (opc[6:5])
            OPC_OP_IMM[6:5]: begin
              if ((funct3 == 3'b001) || (funct3 == 3'b101)) begin
                imm = {27'b0, instr[24:20]};  // Shamt
              end else begin
                imm = {{20{instr[31]}}, instr[31:20]};
              end
              rd       = instr[11:7];
              rs_1     = instr[19:15];
              writes   = 1'b1;
              uses_imm = 1'b1;
              case (funct3)
                3'b000:  name = ADDI;
                3'b001:  name = SLLI;
                3'b010:  name = SLTI;
                3'b011:  name = SLTIU;
                3'b100:  name = XORI;
                3'b101:  name = funct7_b5 ? SRAI : SRLI;
                3'b110:  name = ORI;
                default: name = ANDI;
              endcase
            end
            OPC_OP[6:5]: begin
              rd     = instr[11:7];
              rs_1   = instr[19:15];
              rs_2   = instr[24:20];
              writes = 1'b1;
              case (funct3)
                3'b000:  name = funct7_b5 ? SUB : ADD;
                3'b001:  name = SLL;
                3'b010:  name = SLT;
                3'b011:  name = SLTU;
                3'b100:  name = XOR;
                3'b101:  name = funct7_b5 ? SRA : SRL;
                3'b110:  name = OR;
                default: name = AND;
              endcase
            end
            OPC_SYSTEM[6:5]: name = instr[21] ? EBREAK : ECALL;
            default:         name = UNKNOWN;
          endcase
        end
        3'b101: begin
          if (!opc[6]) begin  // LUI and AUIPC
            imm     = {instr[31:12], 12'b0};
            rd      = instr[11:7];
            writes  = 1'b1;
            st_type = ALU;
            name    = (opc[6:5] == OPC_LUI[6:5]) ? LUI : AUIPC;
          end
        end
        default: name = UNKNOWN;
      endcase
    end
    // Nothing survives from a rejected encoding
    if (name == UNKNOWN) begin
      imm      = '0;
      rd       = '0;
      rs_1     = '0;
      rs_2     = '0;
      writes   = 1'b0;
      jumps    = 1'b0;
      uses_imm = 1'b0;
      st_type  = LS;
    end
  end

  assign instr_info.instr_name = name;
  assign instr_info.immediate  = imm;
  assign instr_info.rd         = rd;
  assign instr_info.rs_1       = rs_1;
  assign instr_info.rs_2       = rs_2;
  assign instr_info.writes     = writes;
  assign instr_info.jumps      = jumps;
  assign instr_info.uses_imm   = uses_imm;
  assign instr_info.st_type    = st_type;

endmodule

// ==== hdl/fetch_if.sv ====
// Fetch to decode channel
`timescale 1ns/100ps

interface fetch_if
  import isa_pkg::*;
();
  logic  valid;
  logic  ready;
  word_t instr;
  addr_t pc;

  modport source (output valid, output instr, output pc, input ready);

  modport decode (input instr);

  modport sink (input valid, input pc, output ready);

endinterface

// ==== hdl/fetch_unit.sv ====
// Sequential instruction fetch
`timescale 1ns/100ps

module fetch_unit
  import isa_pkg::*, frontend_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    stop,
  output logic    wb_cyc,
  output logic    wb_stb,
  output addr_t   wb_adr,
  input  word_t   wb_rdata,
  input  logic    wb_ack,
  fetch_if.source fetch
);
  fetch_state_t state;
  addr_t        pc;
  word_t        slot_instr;
  addr_t        slot_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      pc    <= BOOT_ADDR;
    end else begin
      case (state)
        IDLE: begin
          if (!stop) begin
            state <= BUS;
          end
        end
        BUS: begin
          if (wb_ack) begin
            state <= HOLD;
            pc    <= pc + 32'd4;
          end
        end
        HOLD: begin
          // Slot drains this cycle, chain straight into the next read
          if (fetch.ready) begin
            state <= stop ? IDLE : BUS;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Output slot payload
  always_ff @(posedge clk) begin
    if ((state == BUS) && wb_ack) begin
      slot_instr <= wb_rdata;
      slot_pc    <= pc;
    end
  end

  assign wb_cyc = (state == BUS);
  assign wb_stb = (state == BUS);
  assign wb_adr = pc;  // Stable for the whole cycle

  assign fetch.valid = (state == HOLD);
  assign fetch.instr = slot_instr;
  assign fetch.pc    = slot_pc;

endmodule

// ==== hdl/frontend_pkg.sv ====
// Front end microarchitecture definitions
package frontend_pkg;

  // Reservation station that receives the instruction
  typedef enum logic [1:0] {
    LS,
    BRANCH,
    ALU
  } station_t;

  typedef enum logic [1:0] {
    IDLE,  // No bus cycle, slot empty
    BUS,   // Wishbone read in progress
    HOLD   // Word waiting in the output slot
  } fetch_state_t;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0000;

  localparam int ISSUE_DEPTH = 2;

endpackage

// ==== hdl/instr_info_if.sv ====
// Decoded instruction record
`timescale 1ns/100ps

interface instr_info_if
  import isa_pkg::*, frontend_pkg::*;
();
  instr_name_t instr_name;
  word_t       immediate;
  reg_idx_t    rd;
  reg_idx_t    rs_1;
  reg_idx_t    rs_2;
  logic        writes;
  logic        jumps;
  logic        uses_imm;
  station_t    st_type;

  modport producer (
    output instr_name, immediate, rd, rs_1, rs_2, writes, jumps, uses_imm, st_type
  );

  modport consumer (
    input instr_name, immediate, rd, rs_1, rs_2, writes, jumps, uses_imm, st_type
  );

endinterface

// ==== hdl/isa_pkg.sv ====
// RV32I instruction set definitions
package isa_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [4:0]      reg_idx_t;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD     = 7'b000_0011;
  localparam logic [6:0] OPC_STORE    = 7'b010_0011;
  localparam logic [6:0] OPC_BRANCH   = 7'b110_0011;
  localparam logic [6:0] OPC_JALR     = 7'b110_0111;
  localparam logic [6:0] OPC_JAL      = 7'b110_1111;
  localparam logic [6:0] OPC_MISC_MEM = 7'b000_1111;
  localparam logic [6:0] OPC_OP_IMM   = 7'b001_0011;
  localparam logic [6:0] OPC_OP       = 7'b011_0011;
  localparam logic [6:0] OPC_SYSTEM   = 7'b111_0011;
  localparam logic [6:0] OPC_LUI      = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC    = 7'b001_0111;

  typedef enum logic [5:0] {
    UNKNOWN,
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    JAL,
    JALR,
    ADDI,
    SLTI,
    SLTIU,
    XORI,
    ORI,
    ANDI,
    SLLI,
    SRLI,
    SRAI,
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    ECALL,
    EBREAK,
    LUI,
    AUIPC
  } instr_name_t;

endpackage

// ==== hdl/issue_buffer.sv ====
// Issue queue for decoded instructions
`timescale 1ns/100ps

module issue_buffer
  import isa_pkg::*, frontend_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  fetch_if.sink             fetch,
  instr_info_if.consumer    instr_info,
  output logic              issue_valid,
  input  logic              issue_ready,
  output addr_t             issue_pc,
  output instr_name_t       issue_name,
  output word_t             issue_imm,
  output reg_idx_t          issue_rd,
  output reg_idx_t          issue_rs1,
  output reg_idx_t          issue_rs2,
  output logic              issue_writes,
  output logic              issue_jumps,
  output logic              issue_uses_imm,
  output station_t          issue_station
);
  addr_t       pc_q       [ISSUE_DEPTH];
  instr_name_t name_q     [ISSUE_DEPTH];
  word_t       imm_q      [ISSUE_DEPTH];
  reg_idx_t    rd_q       [ISSUE_DEPTH];
  reg_idx_t    rs1_q      [ISSUE_DEPTH];
  reg_idx_t    rs2_q      [ISSUE_DEPTH];
  logic        writes_q   [ISSUE_DEPTH];
  logic        jumps_q    [ISSUE_DEPTH];
  logic        uses_imm_q [ISSUE_DEPTH];
  station_t    station_q  [ISSUE_DEPTH];

  logic [$clog2(ISSUE_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(ISSUE_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(ISSUE_DEPTH+1)-1:0] count;
  logic                             push;
  logic                             pop;

  assign fetch.ready = (count < ISSUE_DEPTH);
  assign issue_valid = (count != '0);
  assign push        = fetch.valid && fetch.ready;
  assign pop         = issue_valid && issue_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ISSUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ISSUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pc_q[wr_ptr]       <= fetch.pc;
      name_q[wr_ptr]     <= instr_info.instr_name;
      imm_q[wr_ptr]      <= instr_info.immediate;
      rd_q[wr_ptr]       <= instr_info.rd;
      rs1_q[wr_ptr]      <= instr_info.rs_1;
      rs2_q[wr_ptr]      <= instr_info.rs_2;
      writes_q[wr_ptr]   <= instr_info.writes;
      jumps_q[wr_ptr]    <= instr_info.jumps;
      uses_imm_q[wr_ptr] <= instr_info.uses_imm;
      station_q[wr_ptr]  <= instr_info.st_type;
    end
  end

  // Head of queue
  assign issue_pc       = pc_q[rd_ptr];
  assign issue_name     = name_q[rd_ptr];
  assign issue_imm      = imm_q[rd_ptr];
  assign issue_rd       = rd_q[rd_ptr];
  assign issue_rs1      = rs1_q[rd_ptr];
  assign issue_rs2      = rs2_q[rd_ptr];
  assign issue_writes   = writes_q[rd_ptr];
  assign issue_jumps    = jumps_q[rd_ptr];
  assign issue_uses_imm = uses_imm_q[rd_ptr];
  assign issue_station  = station_q[rd_ptr];

endmodule

// ==== tb.f ====
hdl/isa_pkg.sv
hdl/frontend_pkg.sv
hdl/fetch_if.sv
hdl/instr_info_if.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/issue_buffer.sv
hdl/core_frontend.sv
test/tb_core_frontend.sv

// ==== test/tb_core_frontend.sv ====
// Instruction front end testbench
`timescale 1ns/100ps

module tb_core_frontend
  import isa_pkg::*, frontend_pkg::*;
();
  localparam int CYCLE_LIMIT = 4000;
  localparam int MEM_WORDS   = 64;
  localparam int PROG_LEN    = 19;

  localparam instr_name_t LOAD_NAMES [8] = '{LB, LH, LW, UNKNOWN, LBU, LHU, UNKNOWN, UNKNOWN};
  localparam instr_name_t STORE_NAMES [8] = '{SB, SH, SW, UNKNOWN, UNKNOWN, UNKNOWN, UNKNOWN,
                                              UNKNOWN};
  localparam instr_name_t BRANCH_NAMES [8] = '{BEQ, BNE, UNKNOWN, UNKNOWN, BLT, BGE, BLTU, BGEU};
  localparam instr_name_t IMM_NAMES [8] = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, ORI, ANDI};
  localparam instr_name_t REG_NAMES [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};

  typedef struct packed {
    instr_name_t name;
    word_t       imm;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic        writes;
    logic        jumps;
    logic        uses_imm;
    station_t    station;
  } rec_t;

  logic        clk;
  logic        rst;
  logic        stop;
  logic        wb_cyc;
  logic        wb_stb;
  addr_t       wb_adr;
  word_t       wb_rdata;
  logic        wb_ack;
  logic        issue_valid;
  logic        issue_ready;
  addr_t       issue_pc;
  instr_name_t issue_name;
  word_t       issue_imm;
  reg_idx_t    issue_rd;
  reg_idx_t    issue_rs1;
  reg_idx_t    issue_rs2;
  logic        issue_writes;
  logic        issue_jumps;
  logic        issue_uses_imm;
  station_t    issue_station;

  word_t       mem [MEM_WORDS];
  logic [31:0] seed = 32'h7365_9986;
  addr_t       fetched [$];  // Acked but not yet issued, oldest first
  addr_t       next_adr;
  addr_t       cur_adr;
  addr_t       last_pc;
  logic        in_transfer;
  logic        random_ready;
  int          wait_left;
  int          ready_left;
  int          max_wait;
  int          wait_cycles = 0;
  int          starts = 0;
  int          issued = 0;
  int          peak = 0;
  int          cycles = 0;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  core_frontend dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic word_t i_word(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                   logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t r_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t s_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t b_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t u_word(logic [6:0] opc, reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic word_t j_word(reg_idx_t rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // Expected record from the RV32I encoding rules
  function automatic rec_t ref_decode(word_t w);
    rec_t       r;
    logic [2:0] f3;
    word_t      imm_i;
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    r     = '0;
    case (w[6:0])
      OPC_LOAD: begin
        r.name   = LOAD_NAMES[f3];
        r.imm    = imm_i;
        r.rd     = w[11:7];
        r.rs1    = w[19:15];
        r.writes = 1'b1;
      end
      OPC_STORE: begin
        r.name = STORE_NAMES[f3];
        r.imm  = {{20{w[31]}}, w[31:25], w[11:7]};
        r.rs1  = w[19:15];
        r.rs2  = w[24:20];
      end
      OPC_BRANCH: begin
        r.name    = BRANCH_NAMES[f3];
        r.imm     = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        r.rs1     = w[19:15];
        r.rs2     = w[24:20];
        r.jumps   = 1'b1;
        r.station = BRANCH;
      end
      OPC_JALR, OPC_JAL: begin
        r.name    = (w[3]) ? JAL : JALR;
        r.imm     = (w[3]) ? {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0} : imm_i;
        r.rd      = w[11:7];
        r.rs1     = (w[3]) ? 5'd0 : w[19:15];
        r.writes  = 1'b1;
        r.jumps   = 1'b1;
        r.station = BRANCH;
      end
      OPC_MISC_MEM: begin  // Fence as a bare ADDI
        r.name    = ADDI;
        r.station = ALU;
      end
      OPC_OP_IMM: begin
        r.name     = IMM_NAMES[f3];
        r.imm      = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, w[24:20]} : imm_i;
        r.rd       = w[11:7];
        r.rs1      = w[19:15];
        r.writes   = 1'b1;
        r.uses_imm = 1'b1;
        r.station  = ALU;
        if (f3 == 3'd5 && w[30]) begin
          r.name = SRAI;
        end
      end
      OPC_OP: begin
        r.name    = REG_NAMES[f3];
        r.rd      = w[11:7];
        r.rs1     = w[19:15];
        r.rs2     = w[24:20];
        r.writes  = 1'b1;
        r.station = ALU;
        if (w[30] && f3 == 3'd0) begin
          r.name = SUB;
        end else if (w[30] && f3 == 3'd5) begin
          r.name = SRA;
        end
      end
      OPC_SYSTEM: begin
        r.name    = (w[21]) ? EBREAK : ECALL;
        r.station = ALU;
      end
      OPC_LUI, OPC_AUIPC: begin
        r.name    = (w[5]) ? LUI : AUIPC;
        r.imm     = {w[31:12], 12'd0};
        r.rd      = w[11:7];
        r.writes  = 1'b1;
        r.station = ALU;
      end
      default: r.name = UNKNOWN;
    endcase
    if (r.name == UNKNOWN) begin
      r = '0;
    end
    return r;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
    assert (got === want) else begin
      $display("** Error: %s is %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_record(addr_t pc);
    rec_t want;
    want = ref_decode(mem[pc[7:2]]);
    check_value("issue_pc", issue_pc, pc);
    check_value("issue_name", issue_name, want.name);
    check_value("issue_imm", issue_imm, want.imm);
    check_value("issue_rd", issue_rd, want.rd);
    check_value("issue_rs1", issue_rs1, want.rs1);
    check_value("issue_rs2", issue_rs2, want.rs2);
    check_value("issue_writes", issue_writes, want.writes);
    check_value("issue_jumps", issue_jumps, want.jumps);
    check_value("issue_uses_imm", issue_uses_imm, want.uses_imm);
    check_value("issue_station", issue_station, want.station);
  endtask

  task automatic load_program();
    word_t fill;
    for (int i = 0; i < MEM_WORDS; i++) begin
      fill   = next_random();
      mem[i] = {fill[31:2], 2'b11};
    end
    mem[0]  = i_word(OPC_LOAD, 3'd2, 5'd5, 5'd2, 12'hff8);  // lw x5, -8(x2)
    mem[1]  = i_word(OPC_LOAD, 3'd4, 5'd6, 5'd3, 12'd17);  // lbu
    mem[2]  = s_word(3'd1, 5'd8, 5'd7, 12'hffa);  // sh
    mem[3]  = b_word(3'd1, 5'd1, 5'd2, 13'h1ff0);  // bne backwards
    mem[4]  = b_word(3'd7, 5'd3, 5'd4, 13'h0800);  // bgeu
    mem[5]  = j_word(5'd1, 21'h1f_f00c);  // jal
    mem[6]  = i_word(OPC_JALR, 3'd0, 5'd0, 5'd1, 12'd12);
    mem[7]  = i_word(OPC_OP_IMM, 3'd5, 5'd9, 5'd10, {7'b010_0000, 5'd31});  // srai
    mem[8]  = i_word(OPC_OP_IMM, 3'd1, 5'd11, 5'd12, {7'd0, 5'd5});  // slli
    mem[9]  = i_word(OPC_OP_IMM, 3'd0, 5'd13, 5'd14, 12'hfff);  // addi -1
    mem[10] = r_word(7'b010_0000, 5'd17, 5'd16, 3'd0, 5'd15);  // sub
    mem[11] = r_word(7'd0, 5'd20, 5'd19, 3'd3, 5'd18);  // sltu
    mem[12] = u_word(OPC_LUI, 5'd21, 20'hdeadb);
    mem[13] = u_word(OPC_AUIPC, 5'd22, 20'h80000);
    mem[14] = i_word(OPC_MISC_MEM, 3'd0, 5'd0, 5'd0, 12'h0ff);  // fence
    mem[15] = 32'h0000_0073;  // ecall
    mem[16] = 32'h0010_0073;  // ebreak
    mem[17] = 32'h0000_0000;
    mem[18] = i_word(OPC_LOAD, 3'd3, 5'd1, 5'd2, 12'd4);  // ld, not in RV32I
  endtask

  // Wishbone memory with random wait states
  always @(negedge clk) begin
    if (rst) begin
      wb_ack      = 1'b0;
      in_transfer = 1'b0;
      next_adr    = BOOT_ADDR;
    end else if (wb_ack) begin
      wb_ack      = 1'b0;
      in_transfer = 1'b0;
    end else if (wb_cyc) begin
      if (!in_transfer) begin
        in_transfer = 1'b1;
        cur_adr     = wb_adr;
        starts++;
        wait_left   = next_random() % (max_wait + 1);
        check_value("wb_adr", wb_adr, next_adr);
        assert (fetched.size() <= ISSUE_DEPTH) else begin
          $display("A bus cycle started while the issue buffer and the fetch slot were full");
          errors++;
        end
        next_adr = wb_adr + 32'd4;
      end
      check_value("wb_adr", wb_adr, cur_adr);
      check_value("wb_stb", wb_stb, 1'b1);
      if (wait_left == 0) begin
        wb_ack   = 1'b1;
        wb_rdata = mem[wb_adr[7:2]];
      end else begin
        wait_left--;
        wait_cycles++;
      end
    end
  end

  // Issue side back-pressure
  always @(negedge clk) begin
    if (!random_ready) begin
      issue_ready = 1'b1;
    end else if (ready_left == 0) begin
      issue_ready = ~issue_ready;
      ready_left  = next_random() % 8;
    end else begin
      ready_left--;
    end
  end

  // Scoreboard of fetched addresses
  always @(posedge clk) begin
    if (rst) begin
      fetched.delete();
    end else begin
      if (issue_valid && issue_ready) begin
        issued++;
        assert (fetched.size() != 0) else begin
          $display("A record was issued with no fetched word outstanding");
          errors++;
        end
        if (fetched.size() != 0) begin
          last_pc = fetched.pop_front();
          check_record(last_pc);
        end
      end
      if (wb_cyc && wb_ack) begin
        fetched.push_back(wb_adr);
      end
      if (fetched.size() > peak) begin
        peak = fetched.size();
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    rst  = 1'b1;
    stop = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic wait_issued(int n);
    int target;
    target = issued + n;
    while (issued < target) @(negedge clk);
  endtask

  // Stop fetching and let every fetched word leave the issue port
  task automatic drain_pipeline();
    @(negedge clk);
    stop         = 1'b1;
    random_ready = 1'b0;
    @(negedge clk);
    while (wb_cyc || fetched.size() != 0) @(negedge clk);
  endtask

  task automatic report_test(string name, int err_start);
    if (errors == err_start) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d errors", name, errors - err_start);
    end
  endtask

  task automatic reset_state();
    int err_start;
    err_start = errors;
    max_wait  = 0;
    apply_reset();
    check_value("wb_cyc", wb_cyc, 1'b0);
    check_value("wb_stb", wb_stb, 1'b0);
    check_value("issue_valid", issue_valid, 1'b0);
    while (!wb_cyc) @(negedge clk);
    check_value("wb_adr", wb_adr, BOOT_ADDR);
    drain_pipeline();
    report_test("reset state", err_start);
  endtask

  task automatic sequential_fetch();
    int err_start;
    err_start = errors;
    max_wait  = 0;
    apply_reset();
    wait_issued(32);
    drain_pipeline();
    report_test("sequential fetch", err_start);
  endtask

  task automatic decode_program();
    int err_start;
    err_start = errors;
    max_wait  = 0;
    apply_reset();
    wait_issued(PROG_LEN);
    drain_pipeline();
    report_test("decoding", err_start);
  endtask

  task automatic back_pressure();
    int err_start;
    err_start = errors;
    max_wait  = 0;
    apply_reset();
    random_ready = 1'b1;
    peak         = 0;
    wait_issued(24);
    drain_pipeline();
    assert (peak == ISSUE_DEPTH + 1) else begin
      $display("Back-pressure never filled the issue buffer and the fetch slot");
      errors++;
    end
    report_test("back-pressure", err_start);
  endtask

  task automatic stop_and_resume();
    int    err_start;
    int    starts_at_stop;
    addr_t resume_adr;
    err_start = errors;
    max_wait  = 2;
    apply_reset();
    wait_issued(5);
    while (!wb_cyc) @(negedge clk);
    stop = 1'b1;  // Lands inside a bus cycle
    @(posedge clk);
    starts_at_stop = starts;
    resume_adr     = next_adr;
    repeat (16) @(posedge clk);
    assert (starts == starts_at_stop) else begin
      $display("A bus cycle started while stop was high");
      errors++;
    end
    @(negedge clk);
    check_value("fetched words outstanding", fetched.size(), 0);
    check_value("issue_pc of the last record", last_pc, resume_adr - 32'd4);
    stop = 1'b0;
    while (!wb_cyc) @(negedge clk);
    check_value("wb_adr", wb_adr, resume_adr);
    wait_issued(5);
    drain_pipeline();
    report_test("stop", err_start);
  endtask

  task automatic bus_wait_states();
    int err_start;
    int waits_before;
    err_start    = errors;
    waits_before = wait_cycles;
    max_wait     = 3;
    apply_reset();
    wait_issued(32);
    drain_pipeline();
    assert (wait_cycles > waits_before) else begin
      $display("The memory model inserted no wait states");
      errors++;
    end
    report_test("wait states", err_start);
  endtask

  initial begin
    rst          = 1'b1;
    stop         = 1'b0;
    wb_ack       = 1'b0;
    wb_rdata     = '0;
    issue_ready  = 1'b0;
    random_ready = 1'b0;
    ready_left   = 0;
    max_wait     = 0;
    last_pc      = '0;
    load_program();
    reset_state();
    sequential_fetch();
    decode_program();
    back_pressure();
    stop_and_resume();
    bus_wait_states();
    $display("%0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
